// ==== Makefile ====
SIM := verilator
FLAGS := --binary --timing --assert -j 0
TOP := cpuTb
FILELIST := all.f

BIN := obj_dir/V$(TOP)
SOURCES := $(wildcard source/*.sv) $(wildcard verification/*.sv) $(wildcard verification/*.svh)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== all.f ====
+incdir+verification
source/cpuPkg.sv
source/controlLinesIf.sv
source/registerFile.sv
source/aluUnit.sv
source/memoryUnit.sv
source/busDatapath.sv
source/controlSequencer.sv
source/cpuTop.sv
verification/cpuTb.sv

// ==== source/aluUnit.sv ====
// Multiply is unsigned, 32 steps after start; other results are zero-extended to 64 bits
`timescale 1ns/10ps
`default_nettype none

module aluUnit import cpuPkg::*; (
   input logic Clock,
   input logic rstN,
   input aluOpT aluOp,
   input logic start,
   input wordT a,
   input wordT b,
   output logic [2*wordWidth-1:0] result,
   output logic finished
);

   logic mulBusy;
   logic [4:0] count;
   logic [2*wordWidth-1:0] mcand;
   wordT mplier;
   wordT simple;

   always_comb begin
      unique case (aluOp)
         aluAdd: simple = a + b;
         aluSub: simple = a - b;
         aluAnd: simple = a & b;
         aluOr: simple = a | b;
         default: simple = b;
      endcase
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         mulBusy <= 1'b0;
         finished <= 1'b0;
         count <= '0;
      end else begin
         finished <= 1'b0;
         if (start && aluOp == aluMul) begin
            // First shift-and-add step happens on the start edge
            result <= b[0] ? {{wordWidth{1'b0}}, a} : '0;
            mcand <= {{(wordWidth-1){1'b0}}, a, 1'b0};
            mplier <= b >> 1;
            count <= 5'd1;
            mulBusy <= 1'b1;
         end else if (start) begin
            result <= {{wordWidth{1'b0}}, simple};
            finished <= 1'b1;
         end else if (mulBusy) begin
            result <= result + (mplier[0] ? mcand : '0);
            mcand <= mcand << 1;
            mplier <= mplier >> 1;
            count <= count + 5'd1;
            if (count == 5'd31) begin
               mulBusy <= 1'b0;
               finished <= 1'b1;
            end
         end
      end
   end

   // A new operation may not start on top of a running multiply
   assert property (@(posedge Clock) disable iff (!rstN) start |-> !mulBusy);

endmodule

`default_nettype wire

// ==== source/busDatapath.sv ====
// PC is held at zero while idle; LO loads straight from RZ low, HI from the bus
`timescale 1ns/10ps
`default_nettype none

module busDatapath import cpuPkg::*; (
   input logic Clock,
   input logic rstN,
   input logic busy,
   controlLines.datapath ctrl,
   input logic hostValid,
   input logic hostWrite,
   output logic hostReady,
   input memAddrT hostAddr,
   input wordT hostWriteData,
   output wordT hostReadData,
   output logic hostReadValid
);

   wordT bus, pc, ir, ry, hi, lo, imm, regBus, mdr;
   logic [2*wordWidth-1:0] rz, aluResult;
   logic con;

   assign imm = {{(wordWidth-immWidth){ir[immMsb]}}, ir[immMsb:0]};
   assign ctrl.opcode = opcodeT'(ir[opMsb:opLsb]);
   assign ctrl.branch = con;

   always_comb begin
      if (ctrl.pcOut) bus = pc;
      else if (ctrl.mdrOut) bus = mdr;
      else if (ctrl.rzLoOut) bus = rz[wordWidth-1:0];
      else if (ctrl.rzHiOut) bus = rz[2*wordWidth-1:wordWidth];
      else if (ctrl.hiOut) bus = hi;
      else if (ctrl.loOut) bus = lo;
      else if (ctrl.immOut) bus = imm;
      else bus = regBus;
   end

   always_ff @(posedge Clock) begin
      if (!rstN || !busy) pc <= '0;
      else if (ctrl.pcIn) pc <= bus;
      else if (ctrl.incPc) pc <= pc + 1;
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         ir <= '0;
         con <= 1'b0;
      end else begin
         if (ctrl.irIn) ir <= bus;
         // Condition is taken from Ra on the bus
         if (ctrl.conIn) con <= (ctrl.opcode == brzr) ? (bus == '0) : (bus != '0);
      end
   end

   always_ff @(posedge Clock) begin
      if (ctrl.ryIn) ry <= bus;
      if (ctrl.rzIn) rz <= aluResult;
      if (ctrl.hiIn) hi <= bus;
      if (ctrl.loIn) lo <= rz[wordWidth-1:0];
   end

   registerFile regFile (
      .Clock(Clock), .rstN(rstN), .ir(ir),
      .gra(ctrl.gra), .grb(ctrl.grb), .grc(ctrl.grc),
      .rIn(ctrl.rIn), .rOut(ctrl.rOut), .baOut(ctrl.baOut),
      .busIn(bus), .busOut(regBus)
   );

   aluUnit alu (
      .Clock(Clock), .rstN(rstN), .aluOp(ctrl.aluOp), .start(ctrl.start),
      .a(ry), .b(bus), .result(aluResult), .finished(ctrl.finished)
   );

   memoryUnit mem (
      .Clock(Clock), .rstN(rstN), .busy(busy),
      .marIn(ctrl.marIn), .mdrIn(ctrl.mdrIn), .read(ctrl.read), .write(ctrl.write),
      .busIn(bus), .mdr(mdr), .memFinished(ctrl.memFinished),
      .hostValid(hostValid), .hostWrite(hostWrite), .hostReady(hostReady),
      .hostAddr(hostAddr), .hostWriteData(hostWriteData),
      .hostReadData(hostReadData), .hostReadValid(hostReadValid)
   );

endmodule

`default_nettype wire

// ==== source/controlLinesIf.sv ====
// Control lines are plain levels sampled on the datapath clock; no clocking blocks
`timescale 1ns/10ps
`default_nettype none

interface controlLines import cpuPkg::*; ();

   // Bus drive selects
   logic pcOut, mdrOut, rzLoOut, rzHiOut, hiOut, loOut, immOut, rOut, baOut;
   // Register number selects
   logic gra, grb, grc;
   // Register loads
   logic pcIn, irIn, marIn, mdrIn, ryIn, rzIn, hiIn, loIn, rIn, conIn, incPc;
   // ALU and memory
   aluOpT aluOp;
   logic start, read, write;
   // Status back to the sequencer
   opcodeT opcode;
   logic finished, memFinished, branch;

   modport sequencer (
      output pcOut, mdrOut, rzLoOut, rzHiOut, hiOut, loOut, immOut, rOut, baOut,
      output gra, grb, grc,
      output pcIn, irIn, marIn, mdrIn, ryIn, rzIn, hiIn, loIn, rIn, conIn, incPc,
      output aluOp, start, read, write,
      input opcode, finished, memFinished, branch
   );

   modport datapath (
      input pcOut, mdrOut, rzLoOut, rzHiOut, hiOut, loOut, immOut, rOut, baOut,
      input gra, grb, grc,
      input pcIn, irIn, marIn, mdrIn, ryIn, rzIn, hiIn, loIn, rIn, conIn, incPc,
      input aluOp, start, read, write,
      output opcode, finished, memFinished, branch
   );

endinterface

`default_nettype wire

// ==== source/controlSequencer.sv ====
// ld, st and branches use T6 and T7; run must fall after halt before the next run
`timescale 1ns/10ps
`default_nettype none

module controlSequencer import cpuPkg::*; (
   input logic Clock,
   input logic rstN,
   input logic run,
   output logic halted,
   output logic busy,
   controlLines.sequencer ctrl
);

   logic [stateCount-1:0] state, nextState;
   logic wasT4;
   logic isAluR, isAluI, isMem, isBranch, isMove, isLd;

   always_comb begin
      isAluR = ctrl.opcode inside {add, sub, andOp, orOp, mul};
      isAluI = ctrl.opcode inside {addi, andi, ori};
      isMem = ctrl.opcode inside {ld, st};
      isBranch = ctrl.opcode inside {brzr, brnz};
      isMove = ctrl.opcode inside {mfhi, mflo};
      isLd = ctrl.opcode == ld;
   end

   always_comb begin
      nextState = '0;
      unique case (1'b1)
         state[sIdle]: nextState[run ? sT0 : sIdle] = 1'b1;
         state[sT0]: nextState[sT1] = 1'b1;
         state[sT1]: nextState[sT2] = 1'b1;
         state[sT2]: nextState[sT3] = 1'b1;
         state[sT3]: begin
            if (isMove) nextState[sT0] = 1'b1;
            else if (isAluR || isAluI || isMem || isBranch) nextState[sT4] = 1'b1;
            else nextState[sHalt] = 1'b1;
         end
         state[sT4]: nextState[ctrl.finished ? sT5 : sT4] = 1'b1;
         state[sT5]: nextState[(isMem || isBranch) ? sT6 : sT0] = 1'b1;
         state[sT6]: begin
            if (isBranch) nextState[sT0] = 1'b1;
            else if (isLd && !ctrl.memFinished) nextState[sT6] = 1'b1;
            else nextState[sT7] = 1'b1;
         end
         state[sT7]: nextState[(isLd || ctrl.memFinished) ? sT0 : sT7] = 1'b1;
         state[sHalt]: nextState[run ? sHalt : sIdle] = 1'b1;
         default: nextState[sIdle] = 1'b1;
      endcase
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         state <= '0;
         state[sIdle] <= 1'b1;
         wasT4 <= 1'b0;
      end else begin
         state <= nextState;
         wasT4 <= state[sT4];
      end
   end

   assign halted = state[sHalt];
   assign busy = !(state[sIdle] || state[sHalt]);

   // Operation follows the opcode for the whole instruction
   always_comb begin
      unique case (ctrl.opcode)
         add, addi, ld, st, brzr, brnz: ctrl.aluOp = aluAdd;
         sub: ctrl.aluOp = aluSub;
         andOp, andi: ctrl.aluOp = aluAnd;
         orOp, ori: ctrl.aluOp = aluOr;
         mul: ctrl.aluOp = aluMul;
         default: ctrl.aluOp = aluPassB;
      endcase
   end

   always_comb begin
      {ctrl.pcOut, ctrl.mdrOut, ctrl.rzLoOut, ctrl.rzHiOut, ctrl.hiOut} = '0;
      {ctrl.loOut, ctrl.immOut, ctrl.rOut, ctrl.baOut} = '0;
      {ctrl.gra, ctrl.grb, ctrl.grc} = '0;
      {ctrl.pcIn, ctrl.irIn, ctrl.marIn, ctrl.mdrIn, ctrl.ryIn, ctrl.rzIn} = '0;
      {ctrl.hiIn, ctrl.loIn, ctrl.rIn, ctrl.conIn, ctrl.incPc} = '0;
      {ctrl.start, ctrl.read, ctrl.write} = '0;
      // Fetch
      if (state[sT0]) begin
         ctrl.pcOut = 1'b1;
         ctrl.marIn = 1'b1;
         ctrl.incPc = 1'b1;
      end
      if (state[sT1]) begin
         ctrl.read = 1'b1;
         ctrl.mdrIn = 1'b1;
      end
      if (state[sT2]) begin
         ctrl.mdrOut = 1'b1;
         ctrl.irIn = 1'b1;
      end
      // First operand into RY, or a register move
      if (state[sT3]) begin
         if (isMove) begin
            ctrl.hiOut = ctrl.opcode == mfhi;
            ctrl.loOut = ctrl.opcode == mflo;
            ctrl.gra = 1'b1;
            ctrl.rIn = 1'b1;
         end else if (isBranch) begin
            ctrl.pcOut = 1'b1;
            ctrl.ryIn = 1'b1;
         end else begin
            ctrl.grb = 1'b1;
            ctrl.rOut = isAluR || isAluI;
            ctrl.baOut = isMem;
            ctrl.ryIn = 1'b1;
         end
      end
      // Second operand held on the bus until the ALU finishes
      if (state[sT4]) begin
         ctrl.grc = isAluR;
         ctrl.rOut = isAluR;
         ctrl.immOut = !isAluR;
         ctrl.start = !wasT4;
         ctrl.rzIn = ctrl.finished;
      end
      if (state[sT5]) begin
         if (ctrl.opcode == mul) begin
            ctrl.rzHiOut = 1'b1;
            ctrl.hiIn = 1'b1;
            ctrl.loIn = 1'b1;
         end else if (isBranch) begin
            ctrl.gra = 1'b1;
            ctrl.rOut = 1'b1;
            ctrl.conIn = 1'b1;
         end else begin
            ctrl.rzLoOut = 1'b1;
            ctrl.marIn = isMem;
            ctrl.gra = !isMem;
            ctrl.rIn = !isMem;
         end
      end
      if (state[sT6]) begin
         if (isBranch) begin
            ctrl.rzLoOut = 1'b1;
            ctrl.pcIn = ctrl.branch;
         end else if (isLd) begin
            ctrl.read = 1'b1;
            ctrl.mdrIn = 1'b1;
         end else begin
            ctrl.gra = 1'b1;
            ctrl.rOut = 1'b1;
            ctrl.mdrIn = 1'b1;
         end
      end
      if (state[sT7]) begin
         ctrl.mdrOut = isLd;
         ctrl.gra = isLd;
         ctrl.rIn = isLd;
         ctrl.write = !isLd;
      end
   end

   // Bus has a single driver
   assert property (@(posedge Clock) disable iff (!rstN)
      $onehot0({ctrl.pcOut, ctrl.mdrOut, ctrl.rzLoOut, ctrl.rzHiOut, ctrl.hiOut,
                ctrl.loOut, ctrl.immOut, ctrl.rOut, ctrl.baOut}));

   // ALU answers only while T4 waits and never in the start cycle
   assert property (@(posedge Clock) disable iff (!rstN)
      ctrl.finished |-> state[sT4] && !ctrl.start);

endmodule

`default_nettype wire

// ==== source/cpuPkg.sv ====
// Word-addressed memory, unsigned multiply; unknown opcodes are treated as halt
`default_nettype none

package cpuPkg;

   localparam int wordWidth = 32;
   localparam int regCount = 16;
   localparam int memDepth = 512;
   localparam int memAddrWidth = 9;

   typedef logic [wordWidth-1:0] wordT;
   typedef logic [memAddrWidth-1:0] memAddrT;

   typedef enum logic [4:0] {
      ld, st, add, sub, andOp, orOp, addi, andi, ori,
      mul, mfhi, mflo, brzr, brnz, halt
   } opcodeT;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluAnd, aluOr, aluMul, aluPassB
   } aluOpT;

   // Instruction fields
   localparam int opMsb = 31;
   localparam int opLsb = 27;
   localparam int raMsb = 26;
   localparam int raLsb = 23;
   localparam int rbMsb = 22;
   localparam int rbLsb = 19;
   localparam int rcMsb = 18;
   localparam int rcLsb = 15;
   localparam int immMsb = 18;
   localparam int immWidth = 19;

   // One-hot state indices of the sequencer
   localparam int sIdle = 0;
   localparam int sT0 = 1;
   localparam int sT1 = 2;
   localparam int sT2 = 3;
   localparam int sT3 = 4;
   localparam int sT4 = 5;
   localparam int sT5 = 6;
   localparam int sT6 = 7;
   localparam int sT7 = 8;
   localparam int sHalt = 9;
   localparam int stateCount = 10;

endpackage

`default_nettype wire

// ==== source/cpuTop.sv ====
// Program is loaded through the host port while idle; execution starts at address 0 on run
`timescale 1ns/10ps
`default_nettype none

module cpuTop import cpuPkg::*; (
   input logic Clock,
   input logic rstN,
   input logic run,
   output logic halted,
   input logic hostValid,
   input logic hostWrite,
   output logic hostReady,
   input memAddrT hostAddr,
   input wordT hostWriteData,
   output wordT hostReadData,
   output logic hostReadValid
);

   logic busy;

   controlLines ctrlLines ();

   controlSequencer sequencer (
      .Clock(Clock), .rstN(rstN), .run(run), .halted(halted), .busy(busy),
      .ctrl(ctrlLines.sequencer)
   );

   busDatapath datapath (
      .Clock(Clock), .rstN(rstN), .busy(busy), .ctrl(ctrlLines.datapath),
      .hostValid(hostValid), .hostWrite(hostWrite), .hostReady(hostReady),
      .hostAddr(hostAddr), .hostWriteData(hostWriteData),
      .hostReadData(hostReadData), .hostReadValid(hostReadValid)
   );

endmodule

`default_nettype wire

// ==== source/memoryUnit.sv ====
// Host access is honored only while busy is low; MAR keeps the low address bits of the bus
`timescale 1ns/10ps
`default_nettype none

module memoryUnit import cpuPkg::*; (
   input logic Clock,
   input logic rstN,
   input logic busy,
   input logic marIn,
   input logic mdrIn,
   input logic read,
   input logic write,
   input wordT busIn,
   output wordT mdr,
   output logic memFinished,
   input logic hostValid,
   input logic hostWrite,
   output logic hostReady,
   input memAddrT hostAddr,
   input wordT hostWriteData,
   output wordT hostReadData,
   output logic hostReadValid
);

   wordT ram [memDepth];
   memAddrT mar;
   logic hostXfer;

   assign hostReady = !busy;
   assign hostXfer = hostValid && hostReady;

   always_ff @(posedge Clock) begin
      if (marIn) mar <= busIn[memAddrWidth-1:0];
      // Read data comes from RAM, otherwise MDR takes the bus
      if (mdrIn) mdr <= read ? ram[mar] : busIn;
      if (busy && write) ram[mar] <= mdr;
      else if (hostXfer && hostWrite) ram[hostAddr] <= hostWriteData;
      if (hostXfer && !hostWrite) hostReadData <= ram[hostAddr];
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         memFinished <= 1'b0;
         hostReadValid <= 1'b0;
      end else begin
         // One pulse per held request
         memFinished <= (read || write) && !memFinished;
         hostReadValid <= hostXfer && !hostWrite;
      end
   end

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
// Only one of gra, grb and grc may be high at a time; R0 is writable and reads zero only under baOut
`timescale 1ns/10ps
`default_nettype none

module registerFile import cpuPkg::*; (
   input logic Clock,
   input logic rstN,
   input wordT ir,
   input logic gra,
   input logic grb,
   input logic grc,
   input logic rIn,
   input logic rOut,
   input logic baOut,
   input wordT busIn,
   output wordT busOut
);

   wordT regs [regCount];
   logic [3:0] sel;

   // Register number comes from the IR field picked by the select line
   always_comb begin
      if (gra) sel = ir[raMsb:raLsb];
      else if (grb) sel = ir[rbMsb:rbLsb];
      else if (grc) sel = ir[rcMsb:rcLsb];
      else sel = '0;
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (rIn) begin
         regs[sel] <= busIn;
      end
   end

   // Base address reads of R0 give zero
   always_comb begin
      if (baOut && sel == '0) busOut = '0;
      else if (rOut || baOut) busOut = regs[sel];
      else busOut = '0;
   end

endmodule

`default_nettype wire

// ==== verification/cpuTbTasks.svh ====
// Included inside cpuTb; programs start at address 0 and use R0 only as a zero base register
`ifndef cpuTbTasksSvh
`define cpuTbTasksSvh

localparam int dataBase = 256;
localparam int resBase = 320;
localparam int hostBase = 400;

function automatic wordT encodeReg(input opcodeT op, input int ra, input int rb, input int rc);
   return {op, 4'(ra), 4'(rb), 4'(rc), 15'b0};
endfunction

function automatic wordT encodeImm(input opcodeT op, input int ra, input int rb, input int imm);
   return {op, 4'(ra), 4'(rb), 19'(imm)};
endfunction

function automatic wordT signExtendImm(input logic [18:0] imm);
   return wordT'($signed(imm));
endfunction

// Marks result words that the program never wrote
function automatic wordT fillPattern(input int addr);
   memAddrT a;
   a = memAddrT'(addr);
   return {7'h2d, a, 7'h35, ~a};
endfunction

task automatic compareWord(input string name, input wordT expected, input wordT actual);
   checkCount++;
   if (actual !== expected) begin
      errorCount++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
   end
endtask

task automatic compareBit(input string name, input logic expected, input logic actual);
   checkCount++;
   if (actual !== expected) begin
      errorCount++;
      $display("[FAIL] %s: expected %b, actual %b", name, expected, actual);
   end
endtask

task automatic hostWriteWord(input int addr, input wordT data);
   @(posedge Clock);
   hostValid <= 1'b1;
   hostWrite <= 1'b1;
   hostAddr <= memAddrT'(addr);
   hostWriteData <= data;
   @(negedge Clock);
   if (!hostReady) begin
      errorCount++;
      $display("Host write to address %0d was refused because hostReady was low", addr);
   end
   @(posedge Clock);
   hostValid <= 1'b0;
   hostWrite <= 1'b0;
endtask

// Read data must show up exactly one cycle after the transfer edge
task automatic hostReadWord(input int addr, output wordT data);
   @(posedge Clock);
   hostValid <= 1'b1;
   hostWrite <= 1'b0;
   hostAddr <= memAddrT'(addr);
   @(negedge Clock);
   if (!hostReady) begin
      errorCount++;
      $display("Host read of address %0d was refused because hostReady was low", addr);
   end
   compareBit("hostReadValid before transfer", 1'b0, hostReadValid);
   @(posedge Clock);
   hostValid <= 1'b0;
   @(negedge Clock);
   compareBit("hostReadValid after transfer", 1'b1, hostReadValid);
   data = hostReadData;
endtask

task automatic loadProgram(input wordT prog[$]);
   for (int i = 0; i < prog.size(); i++) begin
      hostWriteWord(i, prog[i]);
   end
endtask

task automatic clearResults(input int count);
   for (int i = 0; i < count; i++) begin
      hostWriteWord(resBase + i, fillPattern(resBase + i));
   end
endtask

// Returns on the edge where the sequencer leaves idle
task automatic startProgram();
   @(posedge Clock);
   run <= 1'b1;
   @(posedge Clock);
endtask

task automatic waitForHalt(input string name, input int maxCycles);
   int cycles;
   logic readySeen;
   cycles = 0;
   readySeen = 1'b0;
   do begin
      @(negedge Clock);
      cycles++;
      if (!halted && hostReady) readySeen = 1'b1;
   end while (!halted && cycles < 2 * maxCycles);
   if (!halted) begin
      errorCount++;
      $display("%s: processor did not halt within %0d cycles", name, 2 * maxCycles);
   end
   compareBit({name, " hostReady while running"}, 1'b0, readySeen);
   @(posedge Clock);
   run <= 1'b0;
   @(posedge Clock);
   @(negedge Clock);
   compareBit({name, " halted after run fell"}, 1'b0, halted);
endtask

task automatic testAndi();
   wordT prog[$];
   wordT loaded;
   wordT result;
   loaded = 32'b1010101010;
   prog.push_back(encodeImm(ld, 4, 0, dataBase));
   prog.push_back(encodeImm(andi, 2, 4, 'h7FFFF));
   prog.push_back(encodeImm(st, 2, 0, resBase));
   prog.push_back(encodeReg(halt, 0, 0, 0));
   loadProgram(prog);
   hostWriteWord(dataBase, loaded);
   clearResults(1);
   startProgram();
   waitForHalt("testAndi", andiRun);
   hostReadWord(resBase, result);
   compareWord("testAndi R2", loaded & signExtendImm(19'h7FFFF), result);
endtask

task automatic testAluOps();
   wordT prog[$];
   wordT a, b, result;
   logic [18:0] immA, immB;
   wordT expected [6];
   string names [6];
   opcodeT ops [4];
   a = $urandom;
   b = $urandom;
   immA = 19'($urandom);
   immB = 19'($urandom);
   expected = '{a + b, a - b, a & b, a | b, a + signExtendImm(immA), a | signExtendImm(immB)};
   names = '{"add", "sub", "and", "or", "addi", "ori"};
   ops = '{add, sub, andOp, orOp};
   prog.push_back(encodeImm(ld, 1, 0, dataBase));
   prog.push_back(encodeImm(ld, 2, 0, dataBase + 1));
   for (int i = 0; i < 4; i++) begin
      prog.push_back(encodeReg(ops[i], 3, 1, 2));
      prog.push_back(encodeImm(st, 3, 0, resBase + i));
   end
   prog.push_back(encodeImm(addi, 3, 1, int'(immA)));
   prog.push_back(encodeImm(st, 3, 0, resBase + 4));
   prog.push_back(encodeImm(ori, 3, 1, int'(immB)));
   prog.push_back(encodeImm(st, 3, 0, resBase + 5));
   prog.push_back(encodeReg(halt, 0, 0, 0));
   loadProgram(prog);
   hostWriteWord(dataBase, a);
   hostWriteWord(dataBase + 1, b);
   clearResults(6);
   startProgram();
   waitForHalt("testAluOps", aluRun);
   for (int i = 0; i < 6; i++) begin
      hostReadWord(resBase + i, result);
      compareWord({"testAluOps ", names[i]}, expected[i], result);
   end
endtask

task automatic multiplyCase(input string name, input wordT a, input wordT b);
   wordT prog[$];
   wordT result;
   logic [2*wordWidth-1:0] product;
   product = 64'(a) * 64'(b);
   prog.push_back(encodeImm(ld, 1, 0, dataBase));
   prog.push_back(encodeImm(ld, 2, 0, dataBase + 1));
   prog.push_back(encodeReg(mul, 0, 1, 2));
   prog.push_back(encodeReg(mfhi, 5, 0, 0));
   prog.push_back(encodeReg(mflo, 6, 0, 0));
   prog.push_back(encodeImm(st, 5, 0, resBase));
   prog.push_back(encodeImm(st, 6, 0, resBase + 1));
   prog.push_back(encodeReg(halt, 0, 0, 0));
   loadProgram(prog);
   hostWriteWord(dataBase, a);
   hostWriteWord(dataBase + 1, b);
   clearResults(2);
   startProgram();
   waitForHalt(name, mulRun);
   hostReadWord(resBase, result);
   compareWord({name, " HI"}, product[2*wordWidth-1:wordWidth], result);
   hostReadWord(resBase + 1, result);
   compareWord({name, " LO"}, product[wordWidth-1:0], result);
endtask

task automatic testMultiply();
   multiplyCase("testMultiply random", $urandom, $urandom);
   multiplyCase("testMultiply max", '1, '1);
endtask

// Each branch jumps over the store right after it when taken
task automatic testBranches();
   wordT prog[$];
   wordT marker, nonZero, regValue, result, expected;
   opcodeT brOps [4];
   int brRegs [4];
   int branchPc, target;
   logic taken;
   marker = $urandom;
   nonZero = $urandom | 32'h1;
   brOps = '{brzr, brzr, brnz, brnz};
   brRegs = '{1, 2, 2, 1};
   prog.push_back(encodeImm(ld, 1, 0, dataBase));
   prog.push_back(encodeImm(ld, 2, 0, dataBase + 1));
   prog.push_back(encodeImm(ld, 3, 0, dataBase + 2));
   for (int i = 0; i < 4; i++) begin
      prog.push_back(encodeImm(brOps[i], brRegs[i], 0, 1));
      prog.push_back(encodeImm(st, 3, 0, resBase + i));
   end
   prog.push_back(encodeReg(halt, 0, 0, 0));
   loadProgram(prog);
   hostWriteWord(dataBase, '0);
   hostWriteWord(dataBase + 1, nonZero);
   hostWriteWord(dataBase + 2, marker);
   clearResults(4);
   startProgram();
   waitForHalt("testBranches", branchRun);
   for (int i = 0; i < 4; i++) begin
      regValue = (brRegs[i] == 1) ? '0 : nonZero;
      taken = (brOps[i] == brzr) ? (regValue == '0) : (regValue != '0);
      branchPc = 3 + 2 * i;
      target = branchPc + 1 + 1;
      expected = (taken && target > branchPc + 1) ? fillPattern(resBase + i) : marker;
      hostReadWord(resBase + i, result);
      compareWord($sformatf("testBranches marker %0d", i), expected, result);
   end
endtask

task automatic testHostPort();
   wordT prog[$];
   wordT data [8];
   wordT result;
   logic readySeen;
   for (int i = 0; i < 8; i++) begin
      data[i] = $urandom;
      hostWriteWord(hostBase + i, data[i]);
   end
   for (int i = 0; i < 8; i++) begin
      hostReadWord(hostBase + i, result);
      compareWord("testHostPort readback", data[i], result);
   end
   // A write held during the run must stay blocked
   prog.push_back(encodeImm(ld, 1, 0, dataBase));
   prog.push_back(encodeImm(ld, 2, 0, dataBase + 1));
   prog.push_back(encodeReg(mul, 0, 1, 2));
   prog.push_back(encodeReg(halt, 0, 0, 0));
   loadProgram(prog);
   hostWriteWord(dataBase, $urandom);
   hostWriteWord(dataBase + 1, $urandom);
   readySeen = 1'b0;
   startProgram();
   hostValid <= 1'b1;
   hostWrite <= 1'b1;
   hostAddr <= memAddrT'(hostBase);
   hostWriteData <= ~data[0];
   repeat (10) begin
      @(negedge Clock);
      if (hostReady) readySeen = 1'b1;
   end
   @(posedge Clock);
   hostValid <= 1'b0;
   hostWrite <= 1'b0;
   compareBit("testHostPort hostReady during held write", 1'b0, readySeen);
   waitForHalt("testHostPort", hostRun);
   hostReadWord(hostBase, result);
   compareWord("testHostPort blocked write", data[0], result);
endtask

`endif

// ==== verification/cpuTb.sv ====
// Directed tests with a fixed seed; needs a simulator with timing support, RAM is not cleared by reset
`timescale 1ns/10ps
`default_nettype none

module cpuTb import cpuPkg::*; ();

   localparam int clockPeriod = 8;
   localparam int resetCycles = 4;
   localparam logic [31:0] randSeed = 32'hd391_894f;

   // Program cycles: ALU op 7, mul 38, ld or st 10, branch 8, halt 4
   localparam int andiRun = 10 + 7 + 10 + 4;
   localparam int aluRun = 2 * 10 + 6 * 7 + 6 * 10 + 4;
   localparam int mulRun = 2 * 10 + 38 + 2 * 4 + 2 * 10 + 4;
   localparam int branchRun = 3 * 10 + 4 * 8 + 4 * 10 + 4;
   localparam int hostRun = 2 * 10 + 38 + 4;

   // Each host transfer costs up to 3 cycles, each run a few more for run and halted
   localparam int xferCycles = 3;
   localparam int runOverhead = 6;
   localparam int totalCycles = resetCycles + 2
      + andiRun + 7 * xferCycles + runOverhead
      + aluRun + 29 * xferCycles + runOverhead
      + 2 * (mulRun + 14 * xferCycles + runOverhead)
      + branchRun + 23 * xferCycles + runOverhead
      + hostRun + 23 * xferCycles + 12 + runOverhead;
   localparam int timeoutNs = 4 * totalCycles * clockPeriod;

   logic Clock;
   logic rstN;
   logic run;
   logic halted;
   logic hostValid;
   logic hostWrite;
   logic hostReady;
   memAddrT hostAddr;
   wordT hostWriteData;
   wordT hostReadData;
   logic hostReadValid;

   int errorCount;
   int checkCount;

   cpuTop i_dut (
      .Clock(Clock),
      .rstN(rstN),
      .run(run),
      .halted(halted),
      .hostValid(hostValid),
      .hostWrite(hostWrite),
      .hostReady(hostReady),
      .hostAddr(hostAddr),
      .hostWriteData(hostWriteData),
      .hostReadData(hostReadData),
      .hostReadValid(hostReadValid)
   );

   `include "cpuTbTasks.svh"

   initial begin
      Clock = 1'b0;
      forever #(clockPeriod / 2) Clock = ~Clock;
   end

   // Ends a run that hangs in a handshake
   initial begin
      #(timeoutNs);
      $display("Watchdog expired after %0d ns, the tests did not finish", timeoutNs);
      $display("Simulation FAILED");
      $finish;
   end

   initial begin
      int seedSink;
      errorCount = 0;
      checkCount = 0;
      rstN <= 1'b0;
      run <= 1'b0;
      hostValid <= 1'b0;
      hostWrite <= 1'b0;
      hostAddr <= '0;
      hostWriteData <= '0;
      seedSink = $urandom(randSeed);
      repeat (resetCycles) @(posedge Clock);
      rstN <= 1'b1;
      @(negedge Clock);
      compareBit("reset hostReady", 1'b1, hostReady);
      compareBit("reset halted", 1'b0, halted);
      compareBit("reset hostReadValid", 1'b0, hostReadValid);

      testAndi();
      testAluOps();
      testMultiply();
      testBranches();
      testHostPort();

      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
